/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

  localparam int xlen_c = 32;
  localparam logic [1:0] quadrant_32_c = 2'b11;  // Low opcode bits of every 32-bit word.
  localparam logic [6:0] funct7_base_c = 7'h00;
  localparam logic [6:0] funct7_alt_c = 7'h20;  // SUB and SRA/SRAI.
  localparam logic [11:0] imm_ecall_c = 12'h000;
  localparam logic [11:0] imm_ebreak_c = 12'h001;
  localparam logic [11:0] imm_wfi_c = 12'h105;
  localparam logic [11:0] imm_mret_c = 12'h302;

  typedef logic [xlen_c-1:0] word_t;

  typedef enum logic [4:0] {
    RV_MAJOR_LOAD     = 5'b00000,
    RV_MAJOR_CUSTOM_0 = 5'b00010,
    RV_MAJOR_MISC_MEM = 5'b00011,
    RV_MAJOR_OP_IMM   = 5'b00100,
    RV_MAJOR_AUIPC    = 5'b00101,
    RV_MAJOR_STORE    = 5'b01000,
    RV_MAJOR_CUSTOM_1 = 5'b01010,
    RV_MAJOR_OP       = 5'b01100,
    RV_MAJOR_LUI      = 5'b01101,
    RV_MAJOR_CUSTOM_2 = 5'b10110,
    RV_MAJOR_BRANCH   = 5'b11000,
    RV_MAJOR_JALR     = 5'b11001,
    RV_MAJOR_JAL      = 5'b11011,
    RV_MAJOR_SYSTEM   = 5'b11100,
    RV_MAJOR_CUSTOM_3 = 5'b11110
  } rv_major_t;

  typedef enum logic [1:0] {
    USER       = 2'd0,
    SUPERVISOR = 2'd1,
    MACHINE    = 2'd3
  } privilege_t;

  // --------------------
  // Instruction formats.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    rv_major_t  major;
    logic [1:0] quadrant;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv_major_t   major;
    logic [1:0]  quadrant;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    rv_major_t  major;
    logic [1:0] quadrant;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    rv_major_t  major;
    logic [1:0] quadrant;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    rv_major_t   major;
    logic [1:0]  quadrant;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    rv_major_t  major;
    logic [1:0] quadrant;
  } j_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } rv_insn_u;

  // --------------------
  // Stage payloads.
  typedef struct packed {
    word_t pc;
    word_t insn;
    logic  fault;
  } fetch_data_t;

  typedef struct packed {
    word_t      pc;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
  } common_data_t;

  typedef struct packed {
    logic alu;
    logic mem;
    logic branch;
    logic system;
  } exec_select_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef struct packed {
    alu_op_t op;
    word_t   imm;
    logic    use_imm;
    logic    use_pc;
    logic    illegal;
    logic    fetch_fault;
    word_t   illegal_insn;
  } alu_data_t;

  typedef struct packed {
    logic       is_store;
    logic       is_fence;
    logic [1:0] size;
    logic       is_unsigned;
    word_t      imm;
  } mem_data_t;

  typedef struct packed {
    logic [2:0] cond;
    logic       is_jal;
    logic       is_jalr;
    word_t      imm;
  } branch_data_t;

  typedef struct packed {
    logic [11:0] csr_addr;
    logic [1:0]  csr_op;
    logic        use_uimm;
    logic        is_ecall;
    logic        is_ebreak;
    logic        is_mret;
    logic        is_wfi;
  } system_data_t;

  typedef struct packed {
    alu_data_t    alu_data;
    mem_data_t    mem_data;
    branch_data_t branch_data;
    system_data_t system_data;
  } exec_data_t;

  typedef struct packed {
    common_data_t common;
    exec_select_t exec_select;
    exec_data_t   exec_data;
  } issue_data_t;

endpackage

/* source/decode_alu.sv */
`timescale 1ns/1ps

module decode_alu (
  input  rv_decode_pkg::rv_insn_u     insn_i,
  input  rv_decode_pkg::common_data_t common_i,
  output rv_decode_pkg::alu_data_t    alu_data_o,
  output rv_decode_pkg::common_data_t common_o,
  output logic                        illegal_o
);

  logic is_op;
  logic f7_base;
  logic f7_alt;

  assign is_op = insn_i.r_type.major == rv_decode_pkg::RV_MAJOR_OP;
  assign f7_base = insn_i.r_type.funct7 == rv_decode_pkg::funct7_base_c;
  assign f7_alt = insn_i.r_type.funct7 == rv_decode_pkg::funct7_alt_c;

  always_comb begin
    alu_data_o = '0;
    common_o = common_i;
    illegal_o = 1'b0;

    case (insn_i.r_type.funct3)
      3'd0: alu_data_o.op = (is_op && f7_alt) ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'd1: alu_data_o.op = rv_decode_pkg::ALU_SLL;
      3'd2: alu_data_o.op = rv_decode_pkg::ALU_SLT;
      3'd3: alu_data_o.op = rv_decode_pkg::ALU_SLTU;
      3'd4: alu_data_o.op = rv_decode_pkg::ALU_XOR;
      3'd5: alu_data_o.op = f7_alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'd6: alu_data_o.op = rv_decode_pkg::ALU_OR;
      default: alu_data_o.op = rv_decode_pkg::ALU_AND;
    endcase

    case (insn_i.r_type.major)
      rv_decode_pkg::RV_MAJOR_OP: begin
        common_o.uses_rs1 = 1'b1;
        common_o.uses_rs2 = 1'b1;
        common_o.writes_rd = 1'b1;
        // Only ADD/SUB and SRL/SRA have an alternate funct7.
        if (!(f7_base || (f7_alt && insn_i.r_type.funct3 inside {3'd0, 3'd5}))) begin
          illegal_o = 1'b1;
        end
      end
      rv_decode_pkg::RV_MAJOR_OP_IMM: begin
        common_o.uses_rs1 = 1'b1;
        common_o.writes_rd = 1'b1;
        alu_data_o.use_imm = 1'b1;
        alu_data_o.imm = {{20{insn_i.i_type.imm_11_0[11]}}, insn_i.i_type.imm_11_0};
        if (insn_i.r_type.funct3 == 3'd1 && !f7_base) illegal_o = 1'b1;  // Shamt bit 5 set.
        if (insn_i.r_type.funct3 == 3'd5 && !(f7_base || f7_alt)) illegal_o = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_LUI, rv_decode_pkg::RV_MAJOR_AUIPC: begin
        common_o.writes_rd = 1'b1;
        alu_data_o.op = rv_decode_pkg::ALU_ADD;
        alu_data_o.use_imm = 1'b1;
        alu_data_o.use_pc = insn_i.u_type.major == rv_decode_pkg::RV_MAJOR_AUIPC;
        alu_data_o.imm = {insn_i.u_type.imm_31_12, 12'b0};
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

/* source/decode_mem.sv */
`timescale 1ns/1ps

module decode_mem (
  input  rv_decode_pkg::rv_insn_u     insn_i,
  input  rv_decode_pkg::common_data_t common_i,
  output rv_decode_pkg::mem_data_t    mem_data_o,
  output rv_decode_pkg::common_data_t common_o,
  output logic                        illegal_o
);

  always_comb begin
    mem_data_o = '0;
    common_o = common_i;
    illegal_o = 1'b0;
    mem_data_o.size = insn_i.i_type.funct3[1:0];
    mem_data_o.is_unsigned = insn_i.i_type.funct3[2];

    case (insn_i.i_type.major)
      rv_decode_pkg::RV_MAJOR_LOAD: begin
        common_o.uses_rs1 = 1'b1;
        common_o.writes_rd = 1'b1;
        mem_data_o.imm = {{20{insn_i.i_type.imm_11_0[11]}}, insn_i.i_type.imm_11_0};
        // LB, LH, LW, LBU and LHU only.
        if (insn_i.i_type.funct3 inside {3'd3, 3'd6, 3'd7}) illegal_o = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_STORE: begin
        common_o.uses_rs1 = 1'b1;
        common_o.uses_rs2 = 1'b1;
        mem_data_o.is_store = 1'b1;
        mem_data_o.imm = {{20{insn_i.s_type.imm_11_5[6]}}, insn_i.s_type.imm_11_5,
                          insn_i.s_type.imm_4_0};
        if (insn_i.s_type.funct3[2] || insn_i.s_type.funct3[1:0] == 2'd3) illegal_o = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_MISC_MEM: begin
        mem_data_o.is_fence = 1'b1;
        if (insn_i.i_type.funct3 != 3'd0) illegal_o = 1'b1;  // FENCE.I is not supported.
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

/* source/decode_branch.sv */
`timescale 1ns/1ps

module decode_branch (
  input  rv_decode_pkg::rv_insn_u     insn_i,
  input  rv_decode_pkg::common_data_t common_i,
  output rv_decode_pkg::branch_data_t branch_data_o,
  output rv_decode_pkg::common_data_t common_o,
  output logic                        illegal_o
);

  always_comb begin
    branch_data_o = '0;
    common_o = common_i;
    illegal_o = 1'b0;
    branch_data_o.cond = insn_i.b_type.funct3;

    case (insn_i.b_type.major)
      rv_decode_pkg::RV_MAJOR_BRANCH: begin
        common_o.uses_rs1 = 1'b1;
        common_o.uses_rs2 = 1'b1;
        branch_data_o.imm = {{19{insn_i.b_type.imm_12}}, insn_i.b_type.imm_12,
                             insn_i.b_type.imm_11, insn_i.b_type.imm_10_5,
                             insn_i.b_type.imm_4_1, 1'b0};
        if (insn_i.b_type.funct3[2:1] == 2'b01) illegal_o = 1'b1;  // Codes 2 and 3 are unused.
      end
      rv_decode_pkg::RV_MAJOR_JAL: begin
        common_o.writes_rd = 1'b1;
        branch_data_o.is_jal = 1'b1;
        branch_data_o.imm = {{11{insn_i.j_type.imm_20}}, insn_i.j_type.imm_20,
                             insn_i.j_type.imm_19_12, insn_i.j_type.imm_11,
                             insn_i.j_type.imm_10_1, 1'b0};
      end
      rv_decode_pkg::RV_MAJOR_JALR: begin
        common_o.uses_rs1 = 1'b1;
        common_o.writes_rd = 1'b1;
        branch_data_o.is_jalr = 1'b1;
        branch_data_o.imm = {{20{insn_i.i_type.imm_11_0[11]}}, insn_i.i_type.imm_11_0};
        if (insn_i.i_type.funct3 != 3'd0) illegal_o = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

/* source/decode_system.sv */
`timescale 1ns/1ps

module decode_system (
  input  rv_decode_pkg::rv_insn_u     insn_i,
  input  rv_decode_pkg::common_data_t common_i,
  input  rv_decode_pkg::privilege_t   current_mode_i,
  output rv_decode_pkg::system_data_t system_data_o,
  output rv_decode_pkg::common_data_t common_o,
  output logic                        illegal_o
);

  always_comb begin
    system_data_o = '0;
    common_o = common_i;
    illegal_o = insn_i.i_type.major != rv_decode_pkg::RV_MAJOR_SYSTEM;
    system_data_o.csr_addr = insn_i.i_type.imm_11_0;
    system_data_o.csr_op = insn_i.i_type.funct3[1:0];
    system_data_o.use_uimm = insn_i.i_type.funct3[2];

    if (insn_i.i_type.funct3 == 3'd0) begin
      // Trap and wait words carry no register operands.
      if (insn_i.i_type.rs1 != 5'd0 || insn_i.i_type.rd != 5'd0) illegal_o = 1'b1;
      case (insn_i.i_type.imm_11_0)
        rv_decode_pkg::imm_ecall_c: system_data_o.is_ecall = 1'b1;
        rv_decode_pkg::imm_ebreak_c: system_data_o.is_ebreak = 1'b1;
        rv_decode_pkg::imm_wfi_c: system_data_o.is_wfi = 1'b1;
        rv_decode_pkg::imm_mret_c: begin
          system_data_o.is_mret = 1'b1;
          if (current_mode_i != rv_decode_pkg::MACHINE) illegal_o = 1'b1;
        end
        default: illegal_o = 1'b1;
      endcase
    end else if (insn_i.i_type.funct3 == 3'd4) begin
      illegal_o = 1'b1;
    end else begin
      common_o.uses_rs1 = ~insn_i.i_type.funct3[2];  // The uimm forms reuse rs1 as data.
      common_o.writes_rd = 1'b1;
      if (insn_i.i_type.imm_11_0[9:8] > current_mode_i) illegal_o = 1'b1;
    end
  end

endmodule

/* source/skid_buffer.sv */
`timescale 1ns/1ps

module skid_buffer (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       flush_i,
  input  rv_decode_pkg::issue_data_t data_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  output rv_decode_pkg::issue_data_t data_o,
  output logic                       valid_o,
  input  logic                       ready_i
);

  rv_decode_pkg::issue_data_t skid_data;
  logic main_valid;
  logic ready_q;  // Low exactly when the skid entry holds an item.
  logic push;
  logic pop;
  logic main_free;

  assign push = valid_i & ready_q;
  assign pop = main_valid & ready_i;
  assign main_free = ~main_valid | pop;

  assign ready_o = ready_q;
  assign valid_o = main_valid;

  // --------------------
  // Occupancy.
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      main_valid <= 1'b0;
      ready_q <= 1'b1;
    end else if (flush_i) begin
      main_valid <= 1'b0;
      ready_q <= 1'b1;
    end else if (main_free) begin
      main_valid <= ~ready_q | push;  // Skid entry drains first.
      ready_q <= 1'b1;
    end else if (push) begin
      ready_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (main_free) data_o <= ready_q ? data_i : skid_data;
    if (!main_free && push) skid_data <= data_i;
  end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       flush_req_i,
  output logic                       flush_ack_o,
  input  rv_decode_pkg::fetch_data_t fetch_data_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  input  rv_decode_pkg::privilege_t  current_mode_i,
  output rv_decode_pkg::issue_data_t issue_data_o,
  output logic                       valid_o,
  input  logic                       ready_i
);

  rv_decode_pkg::rv_insn_u insn;
  rv_decode_pkg::common_data_t common, common_final;
  rv_decode_pkg::common_data_t common_alu, common_mem, common_branch, common_system;
  rv_decode_pkg::alu_data_t alu_data, alu_data_or_trap;
  rv_decode_pkg::mem_data_t mem_data;
  rv_decode_pkg::branch_data_t branch_data;
  rv_decode_pkg::system_data_t system_data;
  rv_decode_pkg::exec_select_t exec_select;
  rv_decode_pkg::issue_data_t issue_next, stage_data;
  logic illegal_alu, illegal_mem, illegal_branch, illegal_system;
  logic illegal;
  logic stage_valid;
  logic buf_ready;

  assign insn = fetch_data_i.insn;
  assign ready_o = buf_ready;

  always_comb begin
    common = '0;  // Register-use flags come from the unit decoders.
    common.pc = fetch_data_i.pc;
    common.rd = insn.r_type.rd;
    common.rs1 = insn.r_type.rs1;
    common.rs2 = insn.r_type.rs2;
  end

  decode_alu u_alu (
    .insn_i(insn), .common_i(common), .alu_data_o(alu_data),
    .common_o(common_alu), .illegal_o(illegal_alu)
  );

  decode_mem u_mem (
    .insn_i(insn), .common_i(common), .mem_data_o(mem_data),
    .common_o(common_mem), .illegal_o(illegal_mem)
  );

  decode_branch u_branch (
    .insn_i(insn), .common_i(common), .branch_data_o(branch_data),
    .common_o(common_branch), .illegal_o(illegal_branch)
  );

  decode_system u_system (
    .insn_i(insn), .common_i(common), .current_mode_i(current_mode_i),
    .system_data_o(system_data), .common_o(common_system), .illegal_o(illegal_system)
  );

  // --------------------
  // Unit selection.
  always_comb begin
    illegal = 1'b1;
    exec_select = '0;
    common_final = common;
    case (insn.r_type.major)
      rv_decode_pkg::RV_MAJOR_OP, rv_decode_pkg::RV_MAJOR_OP_IMM,
      rv_decode_pkg::RV_MAJOR_LUI, rv_decode_pkg::RV_MAJOR_AUIPC: begin
        illegal = illegal_alu;
        common_final = common_alu;
        exec_select.alu = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_LOAD, rv_decode_pkg::RV_MAJOR_STORE,
      rv_decode_pkg::RV_MAJOR_MISC_MEM: begin
        illegal = illegal_mem;
        common_final = common_mem;
        exec_select.mem = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_BRANCH, rv_decode_pkg::RV_MAJOR_JAL,
      rv_decode_pkg::RV_MAJOR_JALR: begin
        illegal = illegal_branch;
        common_final = common_branch;
        exec_select.branch = 1'b1;
      end
      rv_decode_pkg::RV_MAJOR_SYSTEM: begin
        illegal = illegal_system;
        common_final = common_system;
        exec_select.system = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
    if (insn.r_type.quadrant != rv_decode_pkg::quadrant_32_c) illegal = 1'b1;

    alu_data_or_trap = alu_data;
    // Bad words travel to the ALU as traps and are resolved at commit.
    if (illegal || fetch_data_i.fault) begin
      exec_select = '0;
      exec_select.alu = 1'b1;
      common_final = common;
      alu_data_or_trap.illegal = 1'b1;
      alu_data_or_trap.fetch_fault = fetch_data_i.fault;
      alu_data_or_trap.illegal_insn = fetch_data_i.insn;
    end

    issue_next.common = common_final;
    issue_next.exec_select = exec_select;
    issue_next.exec_data.alu_data = alu_data_or_trap;
    issue_next.exec_data.mem_data = mem_data;
    issue_next.exec_data.branch_data = branch_data;
    issue_next.exec_data.system_data = system_data;
  end

  // --------------------
  // Decode register.
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) stage_valid <= 1'b0;
    else if (flush_req_i) stage_valid <= 1'b0;
    else if (buf_ready) stage_valid <= valid_i;
  end

  always_ff @(posedge clk_core) begin
    if (buf_ready) stage_data <= issue_next;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) flush_ack_o <= 1'b1;
    else flush_ack_o <= flush_req_i;
  end

  skid_buffer u_skid (
    .clk_core(clk_core), .rst_core_n(rst_core_n), .flush_i(flush_req_i),
    .data_i(stage_data), .valid_i(stage_valid), .ready_o(buf_ready),
    .data_o(issue_data_o), .valid_o(valid_o), .ready_i(ready_i)
  );

endmodule

/* tests/decode_stage_sva.sv */
`timescale 1ns/1ps

module decode_stage_sva (
  input logic                       clk_core,
  input logic                       rst_core_n,
  input logic                       flush_req_i,
  input logic                       flush_ack_i,
  input logic                       out_valid_i,
  input logic                       out_ready_i,
  input rv_decode_pkg::issue_data_t out_data_i
);

  // A stalled item keeps both its valid and its payload.
  stall_holds_item: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    out_valid_i && !out_ready_i && !flush_req_i |=> out_valid_i && $stable(out_data_i))
    else $error("valid_o or issue_data_o changed while the output was stalled");

  flush_empties_output: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    flush_req_i |=> !out_valid_i)
    else $error("valid_o was high in the cycle after a flush");

  ack_follows_flush: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    1'b1 |=> flush_ack_i == $past(flush_req_i))
    else $error("flush_ack_o did not follow flush_req_i by one cycle");

endmodule

bind decode_stage decode_stage_sva u_sva (
  .clk_core(clk_core), .rst_core_n(rst_core_n), .flush_req_i(flush_req_i),
  .flush_ack_i(flush_ack_o), .out_valid_i(valid_o), .out_ready_i(ready_i),
  .out_data_i(issue_data_o)
);

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;

  localparam int num_words = 2000;
  localparam int timeout_cycles = num_words * 20 + 1000;

  logic clk_core;
  logic rst_core_n;
  logic flush_req;
  logic flush_ack;
  rv_decode_pkg::fetch_data_t fetch_data;
  logic in_valid;
  logic in_ready;
  rv_decode_pkg::privilege_t mode;
  rv_decode_pkg::issue_data_t issue_data;
  logic out_valid;
  logic out_ready;

  rv_decode_pkg::issue_data_t exp_q[$];
  int errors;
  int checked;
  int accepted;
  logic in_fire;
  logic out_fire;
  logic prev_flush;

  decode_stage u_dut (
    .clk_core(clk_core), .rst_core_n(rst_core_n),
    .flush_req_i(flush_req), .flush_ack_o(flush_ack),
    .fetch_data_i(fetch_data), .valid_i(in_valid), .ready_o(in_ready),
    .current_mode_i(mode),
    .issue_data_o(issue_data), .valid_o(out_valid), .ready_i(out_ready)
  );

  initial begin
    clk_core = 1'b0;
    forever #2 clk_core = ~clk_core;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_core);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------
  // Stimulus.
  function automatic logic [6:0] pick_funct7();
    case ($urandom_range(0, 3))
      0, 1: return 7'h00;
      2: return 7'h20;
      default: return 7'($urandom());
    endcase
  endfunction

  function automatic logic [31:0] make_word();
    logic [31:0] w;
    int unsigned k;
    w = $urandom();
    k = $urandom_range(0, 99);
    if (k < 95) w[1:0] = 2'b11;  // The last few keep a random quadrant.
    if (k < 12) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_OP;
      w[31:25] = pick_funct7();
    end else if (k < 22) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_OP_IMM;
      if (w[13:12] == 2'b01) w[31:25] = pick_funct7();  // Shifts.
    end else if (k < 26) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_LUI;
    end else if (k < 30) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_AUIPC;
    end else if (k < 40) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_LOAD;
    end else if (k < 48) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_STORE;
    end else if (k < 51) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_MISC_MEM;
      if ($urandom_range(0, 3) != 0) w[14:12] = 3'd0;
    end else if (k < 60) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_BRANCH;
    end else if (k < 64) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_JAL;
    end else if (k < 68) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_JALR;
      if ($urandom_range(0, 3) != 0) w[14:12] = 3'd0;
    end else if (k < 80) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_SYSTEM;
      w[14:12] = 3'($urandom_range(1, 7));
    end else if (k < 88) begin
      w[6:2] = rv_decode_pkg::RV_MAJOR_SYSTEM;
      w[14:12] = 3'd0;
      if ($urandom_range(0, 7) != 0) begin
        w[19:15] = 5'd0;
        w[11:7] = 5'd0;
      end
      case ($urandom_range(0, 4))
        0: w[31:20] = 12'h000;
        1: w[31:20] = 12'h001;
        2: w[31:20] = 12'h105;
        3: w[31:20] = 12'h302;
        default: w[31:20] = w[31:20];
      endcase
    end else if (k < 93) begin
      case ($urandom_range(0, 3))
        0: w[6:2] = rv_decode_pkg::RV_MAJOR_CUSTOM_0;
        1: w[6:2] = rv_decode_pkg::RV_MAJOR_CUSTOM_1;
        2: w[6:2] = rv_decode_pkg::RV_MAJOR_CUSTOM_2;
        default: w[6:2] = rv_decode_pkg::RV_MAJOR_CUSTOM_3;
      endcase
    end
    return w;
  endfunction

  task automatic drive_inputs(input logic taken, input logic more);
    if (taken || !in_valid) begin
      in_valid = more && ($urandom_range(0, 3) != 0);
      fetch_data.pc = {30'($urandom_range(0, 32'hffff)), 2'b00};
      fetch_data.insn = make_word();
      fetch_data.fault = $urandom_range(0, 19) == 0;
      case ($urandom_range(0, 3))
        0: mode = rv_decode_pkg::USER;
        1: mode = rv_decode_pkg::SUPERVISOR;
        default: mode = rv_decode_pkg::MACHINE;
      endcase
    end
    out_ready = !more || ($urandom_range(0, 9) < 6);
    flush_req = more && ($urandom_range(0, 49) == 0);
  endtask

  // --------------------
  // Reference decoder.
  function automatic rv_decode_pkg::alu_op_t alu_op_for(input logic [2:0] f3,
                                                         input logic [6:0] f7,
                                                         input logic is_op);
    case (f3)
      3'd0: return (is_op && f7 == 7'h20) ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'd1: return rv_decode_pkg::ALU_SLL;
      3'd2: return rv_decode_pkg::ALU_SLT;
      3'd3: return rv_decode_pkg::ALU_SLTU;
      3'd4: return rv_decode_pkg::ALU_XOR;
      3'd5: return (f7 == 7'h20) ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'd6: return rv_decode_pkg::ALU_OR;
      default: return rv_decode_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rv_decode_pkg::issue_data_t expect_issue(
      input rv_decode_pkg::fetch_data_t f, input rv_decode_pkg::privilege_t m);
    rv_decode_pkg::issue_data_t e;
    logic [31:0] w;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] imm_i;
    logic bad;
    w = f.insn;
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    e = '0;
    bad = 1'b0;
    e.common.pc = f.pc;
    e.common.rd = w[11:7];
    e.common.rs1 = w[19:15];
    e.common.rs2 = w[24:20];
    case (w[6:2])
      rv_decode_pkg::RV_MAJOR_OP: begin
        e.exec_select.alu = 1'b1;
        e.common.uses_rs1 = 1'b1;
        e.common.uses_rs2 = 1'b1;
        e.common.writes_rd = 1'b1;
        e.exec_data.alu_data.op = alu_op_for(f3, f7, 1'b1);
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      rv_decode_pkg::RV_MAJOR_OP_IMM: begin
        e.exec_select.alu = 1'b1;
        e.common.uses_rs1 = 1'b1;
        e.common.writes_rd = 1'b1;
        e.exec_data.alu_data.op = alu_op_for(f3, f7, 1'b0);
        e.exec_data.alu_data.imm = imm_i;
        e.exec_data.alu_data.use_imm = 1'b1;
        bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end
      rv_decode_pkg::RV_MAJOR_LUI, rv_decode_pkg::RV_MAJOR_AUIPC: begin
        e.exec_select.alu = 1'b1;
        e.common.writes_rd = 1'b1;
        e.exec_data.alu_data.op = rv_decode_pkg::ALU_ADD;
        e.exec_data.alu_data.imm = {w[31:12], 12'b0};
        e.exec_data.alu_data.use_imm = 1'b1;
        e.exec_data.alu_data.use_pc = w[6:2] == rv_decode_pkg::RV_MAJOR_AUIPC;
      end
      rv_decode_pkg::RV_MAJOR_LOAD, rv_decode_pkg::RV_MAJOR_STORE,
      rv_decode_pkg::RV_MAJOR_MISC_MEM: begin
        e.exec_select.mem = 1'b1;
        e.exec_data.mem_data.size = f3[1:0];
        e.exec_data.mem_data.is_unsigned = f3[2];
        if (w[6:2] == rv_decode_pkg::RV_MAJOR_LOAD) begin
          e.common.uses_rs1 = 1'b1;
          e.common.writes_rd = 1'b1;
          e.exec_data.mem_data.imm = imm_i;
          bad = f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7;
        end else if (w[6:2] == rv_decode_pkg::RV_MAJOR_STORE) begin
          e.common.uses_rs1 = 1'b1;
          e.common.uses_rs2 = 1'b1;
          e.exec_data.mem_data.is_store = 1'b1;
          e.exec_data.mem_data.imm = {{20{w[31]}}, w[31:25], w[11:7]};
          bad = f3[2] || f3[1:0] == 2'd3;
        end else begin
          e.exec_data.mem_data.is_fence = 1'b1;
          bad = f3 != 3'd0;
        end
      end
      rv_decode_pkg::RV_MAJOR_BRANCH: begin
        e.exec_select.branch = 1'b1;
        e.common.uses_rs1 = 1'b1;
        e.common.uses_rs2 = 1'b1;
        e.exec_data.branch_data.cond = f3;
        e.exec_data.branch_data.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        bad = f3 == 3'd2 || f3 == 3'd3;
      end
      rv_decode_pkg::RV_MAJOR_JAL: begin
        e.exec_select.branch = 1'b1;
        e.common.writes_rd = 1'b1;
        e.exec_data.branch_data.cond = f3;
        e.exec_data.branch_data.is_jal = 1'b1;
        e.exec_data.branch_data.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      rv_decode_pkg::RV_MAJOR_JALR: begin
        e.exec_select.branch = 1'b1;
        e.common.uses_rs1 = 1'b1;
        e.common.writes_rd = 1'b1;
        e.exec_data.branch_data.cond = f3;
        e.exec_data.branch_data.is_jalr = 1'b1;
        e.exec_data.branch_data.imm = imm_i;
        bad = f3 != 3'd0;
      end
      rv_decode_pkg::RV_MAJOR_SYSTEM: begin
        e.exec_select.system = 1'b1;
        e.exec_data.system_data.csr_addr = w[31:20];
        e.exec_data.system_data.csr_op = f3[1:0];
        e.exec_data.system_data.use_uimm = f3[2];
        if (f3 == 3'd0) begin
          bad = w[19:15] != 5'd0 || w[11:7] != 5'd0;
          case (w[31:20])
            12'h000: e.exec_data.system_data.is_ecall = 1'b1;
            12'h001: e.exec_data.system_data.is_ebreak = 1'b1;
            12'h105: e.exec_data.system_data.is_wfi = 1'b1;
            12'h302: begin
              e.exec_data.system_data.is_mret = 1'b1;
              if (m != rv_decode_pkg::MACHINE) bad = 1'b1;
            end
            default: bad = 1'b1;
          endcase
        end else if (f3 == 3'd4) begin
          bad = 1'b1;
        end else begin
          e.common.uses_rs1 = !f3[2];
          e.common.writes_rd = 1'b1;
          if (w[29:28] > m) bad = 1'b1;  // CSR address bits 9:8 give its privilege.
        end
      end
      default: bad = 1'b1;
    endcase
    if (w[1:0] != 2'b11) bad = 1'b1;
    if (bad || f.fault) begin
      e.exec_select = '0;
      e.exec_select.alu = 1'b1;
      e.common.uses_rs1 = 1'b0;
      e.common.uses_rs2 = 1'b0;
      e.common.writes_rd = 1'b0;
      e.exec_data.alu_data.illegal = 1'b1;
      e.exec_data.alu_data.fetch_fault = f.fault;
      e.exec_data.alu_data.illegal_insn = w;
    end
    return e;
  endfunction

  // --------------------
  // Compare tasks.
  task automatic check_issue(input rv_decode_pkg::issue_data_t got,
                             input rv_decode_pkg::issue_data_t exp);
    logic ok;
    ok = got.common == exp.common && got.exec_select == exp.exec_select;
    if (exp.exec_data.alu_data.illegal) begin
      ok = ok && got.exec_data.alu_data.illegal
              && got.exec_data.alu_data.fetch_fault == exp.exec_data.alu_data.fetch_fault
              && got.exec_data.alu_data.illegal_insn == exp.exec_data.alu_data.illegal_insn;
    end else if (exp.exec_select.alu) begin
      ok = ok && got.exec_data.alu_data == exp.exec_data.alu_data;
    end else if (exp.exec_select.mem) begin
      ok = ok && got.exec_data.mem_data == exp.exec_data.mem_data;
    end else if (exp.exec_select.branch) begin
      ok = ok && got.exec_data.branch_data == exp.exec_data.branch_data;
    end else begin
      ok = ok && got.exec_data.system_data == exp.exec_data.system_data;
    end
    if (!ok) begin
      errors++;
      $display("MISMATCH at %0t: issue for pc %h got %h expected %h",
               $time, exp.common.pc, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Main sequence and scoreboard.
  initial begin
    void'($urandom(32'he57f));
    errors = 0;
    checked = 0;
    accepted = 0;
    rst_core_n = 1'b0;
    flush_req = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    fetch_data = '0;
    mode = rv_decode_pkg::MACHINE;
    repeat (10) @(posedge clk_core);
    #1 rst_core_n = 1'b1;
    @(negedge clk_core);
    check_flag(out_valid, 1'b0, "valid_o after reset");
    check_flag(flush_ack, 1'b1, "flush_ack_o after reset");
    check_flag(in_ready, 1'b1, "ready_o after reset");
    prev_flush = 1'b1;  // The acknowledge leaves reset high.

    // Outputs are sampled mid-cycle, where they hold the values seen by the next edge.
    while (accepted < num_words || exp_q.size() != 0 || out_valid) begin
      check_flag(flush_ack, prev_flush, "flush_ack_o");
      in_fire = in_valid && in_ready;
      out_fire = out_valid && out_ready;
      if (flush_req) begin
        exp_q.delete();  // Everything up to and including this cycle is dropped.
        if (in_fire) accepted++;
      end else begin
        if (out_fire && exp_q.size() == 0) begin
          errors++;
          $display("Unexpected output item at %0t with no accepted word pending", $time);
        end else if (out_fire) begin
          check_issue(issue_data, exp_q.pop_front());
          checked++;
        end
        if (in_fire) begin
          exp_q.push_back(expect_issue(fetch_data, mode));
          accepted++;
        end
      end
      prev_flush = flush_req;
      @(posedge clk_core);
      #1;
      drive_inputs(in_fire, accepted < num_words);
      @(negedge clk_core);
    end

    $display("Checked %0d items from %0d words, %0d errors", checked, accepted, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/rv_decode_pkg.sv
source/decode_alu.sv
source/decode_mem.sv
source/decode_branch.sv
source/decode_system.sv
source/skid_buffer.sv
source/decode_stage.sv
tests/decode_stage_sva.sv
tests/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
  -f filelist.f -o tb_decode_stage > build.log 2>&1 \
  && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
  || echo "Build or run stopped with an error, see build.log and sim.log."
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
  && echo "Decode stage simulation passed." \
  || { echo "Decode stage simulation failed."; exit 1; }
